// ==== src/opreq_pkg.sv ====
// Operand requester shared definitions
// VRF word and address geometry, command field types and FSM states

package opreq_pkg;

  //////////////////////////////////////////////////
  // VRF geometry
  //////////////////////////////////////////////////

  // One VRF word is a full 64-bit element slot
  localparam int unsigned ElenBits   = 64;
  // Word address, low bits pick the bank and the rest is the row
  localparam int unsigned VAddrWidth = 10;
  // Words held by one vector register in this lane
  localparam int unsigned RegWords   = 8;

  typedef logic [ElenBits-1:0]   elen_t;
  typedef logic [VAddrWidth-1:0] vaddr_t;

  //////////////////////////////////////////////////
  // Command fields
  //////////////////////////////////////////////////

  // Vector length in elements, 0 to 256
  typedef logic [8:0] vlen_t;
  // Architectural vector register index
  typedef logic [4:0] vreg_t;

  // Element width, a word holds 8, 4, 2 or 1 elements
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } eew_e;

  // Requester FSM states
  typedef enum logic {
    IDLE,
    REQUESTING
  } state_e;

endpackage

// ==== src/bank_req_if.sv ====
// Bank request bundle of one operand requester
// Carries the word request level, its address and the per-bank grants

`timescale 1ns/10ps

interface bank_req_if #(
  parameter int unsigned NrBanks = 4
);
  import opreq_pkg::*;

  // Held high together with addr until a grant arrives
  logic               req;
  vaddr_t             addr;
  // One grant bit per bank, at most one set in a cycle
  logic [NrBanks-1:0] gnt;

  modport requester (
    output req,
    input  gnt
  );

  modport counter (
    output addr
  );

  modport arbiter (
    input  req,
    input  addr,
    output gnt
  );

endinterface

// ==== src/requester_fsm.sv ====
// Operand requester control FSM
// Accepts read commands and raises word requests while the operand queue has room

`timescale 1ns/10ps

module requester_fsm #(
  parameter int unsigned NrBanks = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  // Read command
  input  logic             cmd_valid_i,
  input  opreq_pkg::eew_e  cmd_eew_i,
  input  opreq_pkg::vlen_t cmd_vl_i,
  output logic             cmd_ready_o,
  // Operand queue side
  input  logic             opq_ready_i,
  output logic             opq_cmd_valid_o,
  // Word counter side
  input  logic             last_i,
  output logic             load_o,
  bank_req_if.requester    breq
);
  import opreq_pkg::*;

  localparam int unsigned SumWidth = $bits(vlen_t) + 1;

  state_e state_d, state_q;

  logic [NrBanks-1:0]  bank_gnt;
  logic                gnt;
  logic                finishing;
  logic [1:0]          epw_log2;
  logic [3:0]          epw_m1;
  logic [SumWidth-1:0] vl_rounded;
  logic                has_words;

  // A grant from any bank serves the current word
  assign bank_gnt = breq.gnt;
  assign gnt      = |bank_gnt;

  // Last word leaves in this cycle
  assign finishing = (state_q == REQUESTING) && gnt && last_i;

  // Ready only answers a valid command
  assign cmd_ready_o = cmd_valid_i && ((state_q == IDLE) || finishing);

  // Zero-length commands round down to no words at all
  assign epw_log2   = 2'(EW64) - 2'(cmd_eew_i);
  assign epw_m1     = (4'd1 << epw_log2) - 4'd1;
  assign vl_rounded = SumWidth'(cmd_vl_i) + SumWidth'(epw_m1);
  assign has_words  = (vl_rounded >> epw_log2) != '0;

  assign load_o          = cmd_ready_o && has_words;
  assign opq_cmd_valid_o = load_o;

  // No request while the operand queue is full
  assign breq.req = (state_q == REQUESTING) && opq_ready_i;

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    if (finishing) begin
      state_d = IDLE;
    end
    // Back-to-back command overrides the return to IDLE
    if (load_o) begin
      state_d = REQUESTING;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== src/word_counter.sv ====
// Operand word pointer
// Turns a command into a start address and word count, then walks the words

`timescale 1ns/10ps

module word_counter (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             load_i,
  // Command fields
  input  opreq_pkg::vreg_t cmd_vs_i,
  input  opreq_pkg::eew_e  cmd_eew_i,
  input  opreq_pkg::vlen_t cmd_vl_i,
  // One word was granted
  input  logic             step_i,
  output opreq_pkg::vlen_t words_o,
  output logic             last_o,
  bank_req_if.counter      breq
);
  import opreq_pkg::*;

  localparam int unsigned SumWidth = $bits(vlen_t) + 1;

  vaddr_t              addr_q;
  vlen_t               remaining_q;
  vaddr_t              start_addr;
  logic [1:0]          epw_log2;
  logic [3:0]          epw_m1;
  logic [SumWidth-1:0] vl_rounded;

  // Ceiling of vl over the elements per word
  assign epw_log2   = 2'(EW64) - 2'(cmd_eew_i);
  assign epw_m1     = (4'd1 << epw_log2) - 4'd1;
  assign vl_rounded = SumWidth'(cmd_vl_i) + SumWidth'(epw_m1);
  assign words_o    = vlen_t'(vl_rounded >> epw_log2);

  // Registers are laid out back to back in the word space
  assign start_addr = vaddr_t'(cmd_vs_i * RegWords);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q      <= '0;
      remaining_q <= '0;
    end else if (load_i) begin
      addr_q      <= start_addr;
      remaining_q <= words_o;
    end else if (step_i) begin
      addr_q      <= addr_q + vaddr_t'(1);
      remaining_q <= remaining_q - vlen_t'(1);
    end
  end

  assign last_o    = (remaining_q == vlen_t'(1));
  assign breq.addr = addr_q;

endmodule

// ==== src/bank_arbiter.sv ====
// Round-robin arbiter of one VRF bank
// Picks among the operand reads and the write-back, and drives the bank port

`timescale 1ns/10ps

module bank_arbiter #(
  parameter  int unsigned NrBanks  = 4,
  parameter  int unsigned NrQueues = 2,
  parameter  int unsigned BankIdx  = 0,
  localparam int unsigned BankBits = $clog2(NrBanks),
  localparam int unsigned RowWidth = opreq_pkg::VAddrWidth - BankBits,
  localparam int unsigned TgtWidth = (NrQueues > 1) ? $clog2(NrQueues) : 1
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Operand requesters
  bank_req_if.arbiter         breq [NrQueues],
  // Write-back port
  input  logic                wb_req_i,
  input  opreq_pkg::vaddr_t   wb_addr_i,
  input  opreq_pkg::elen_t    wb_wdata_i,
  output logic                wb_gnt_o,
  // VRF bank port
  output logic                vrf_req_o,
  output logic [RowWidth-1:0] vrf_addr_o,
  output logic                vrf_wen_o,
  output opreq_pkg::elen_t    vrf_wdata_o,
  output logic [TgtWidth-1:0] vrf_tgt_o
);
  import opreq_pkg::*;

  // Inputs 0 to NrQueues-1 are reads, the last one is the write-back
  localparam int unsigned NrIn     = NrQueues + 1;
  localparam int unsigned PtrWidth = $clog2(NrIn);

  vaddr_t [NrIn-1:0]   in_addr;
  logic   [NrIn-1:0]   in_valid;
  logic   [NrIn-1:0]   in_req;
  logic   [NrIn-1:0]   gnt_vec;
  logic [PtrWidth-1:0] rr_d, rr_q;
  logic [PtrWidth-1:0] win_idx;

  for (genvar q = 0; q < NrQueues; q++) begin : gen_queue_in
    assign in_addr[q]           = breq[q].addr;
    assign in_valid[q]          = breq[q].req;
    assign breq[q].gnt[BankIdx] = gnt_vec[q];
  end

  assign in_addr[NrQueues]  = wb_addr_i;
  assign in_valid[NrQueues] = wb_req_i;

  // Keep only the requests that target this bank
  for (genvar i = 0; i < NrIn; i++) begin : gen_bank_mask
    assign in_req[i] = in_valid[i] && (in_addr[i][BankBits-1:0] == BankBits'(BankIdx));
  end

  //////////////////////////////////////////////////
  // Round-robin pick
  //////////////////////////////////////////////////

  // Search starts at the pointer and wraps around once
  always_comb begin
    int unsigned idx;
    gnt_vec = '0;
    win_idx = rr_q;
    for (int unsigned i = 0; i < NrIn; i++) begin
      idx = 32'(rr_q) + i;
      if (idx >= NrIn) begin
        idx = idx - NrIn;
      end
      if (in_req[idx] && !(|gnt_vec)) begin
        gnt_vec[idx] = 1'b1;
        win_idx      = PtrWidth'(idx);
      end
    end
  end

  // Pointer moves just past the winner
  assign rr_d = (win_idx == PtrWidth'(NrIn - 1)) ? '0 : win_idx + PtrWidth'(1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (vrf_req_o) begin
      rr_q <= rr_d;
    end
  end

  //////////////////////////////////////////////////
  // Bank port, acknowledged in the same cycle
  //////////////////////////////////////////////////

  assign vrf_req_o   = |in_req;
  assign vrf_wen_o   = gnt_vec[NrQueues];
  assign wb_gnt_o    = gnt_vec[NrQueues];
  assign vrf_addr_o  = in_addr[win_idx][VAddrWidth-1:BankBits];
  assign vrf_wdata_o = vrf_wen_o ? wb_wdata_i : '0;
  // Queue index of the read, meaningless on a write
  assign vrf_tgt_o   = TgtWidth'(win_idx);

endmodule

// ==== src/operand_requester_top.sv ====
// Operand requester for one lane of a banked VRF
// Per-queue read requesters and a round-robin arbiter in front of every bank

`timescale 1ns/10ps

module operand_requester_top #(
  parameter  int unsigned NrBanks  = 4,
  parameter  int unsigned NrQueues = 2,
  localparam int unsigned RowWidth = opreq_pkg::VAddrWidth - $clog2(NrBanks),
  localparam int unsigned TgtWidth = (NrQueues > 1) ? $clog2(NrQueues) : 1
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // Read commands, one per queue
  input  logic             [NrQueues-1:0]       cmd_valid_i,
  output logic             [NrQueues-1:0]       cmd_ready_o,
  input  opreq_pkg::vreg_t [NrQueues-1:0]       cmd_vs_i,
  input  opreq_pkg::eew_e  [NrQueues-1:0]       cmd_eew_i,
  input  opreq_pkg::vlen_t [NrQueues-1:0]       cmd_vl_i,
  // Operand queues
  input  logic             [NrQueues-1:0]       opq_ready_i,
  output logic             [NrQueues-1:0]       opq_cmd_valid_o,
  output opreq_pkg::vlen_t [NrQueues-1:0]       opq_cmd_words_o,
  output logic             [NrQueues-1:0]       operand_issued_o,
  // Write-back
  input  logic                                  wb_req_i,
  input  opreq_pkg::vaddr_t                     wb_addr_i,
  input  opreq_pkg::elen_t                      wb_wdata_i,
  output logic                                  wb_gnt_o,
  // VRF, one port per bank
  output logic             [NrBanks-1:0]                vrf_req_o,
  output logic             [NrBanks-1:0][RowWidth-1:0]  vrf_addr_o,
  output logic             [NrBanks-1:0]                vrf_wen_o,
  output opreq_pkg::elen_t [NrBanks-1:0]                vrf_wdata_o,
  output logic             [NrBanks-1:0][TgtWidth-1:0]  vrf_tgt_o
);

  bank_req_if #(.NrBanks(NrBanks)) breq [NrQueues] ();

  logic [NrQueues-1:0] q_last;
  logic [NrQueues-1:0] q_load;
  logic [NrQueues-1:0] q_issued;
  logic [NrBanks-1:0]  bank_wb_gnt;

  //////////////////////////////////////////////////
  // Requesters
  //////////////////////////////////////////////////

  for (genvar q = 0; q < NrQueues; q++) begin : gen_requester
    // A word leaves when any bank grants it
    assign q_issued[q] = |breq[q].gnt;

    requester_fsm #(
      .NrBanks(NrBanks)
    ) i_requester_fsm (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .cmd_valid_i    (cmd_valid_i[q]),
      .cmd_eew_i      (cmd_eew_i[q]),
      .cmd_vl_i       (cmd_vl_i[q]),
      .cmd_ready_o    (cmd_ready_o[q]),
      .opq_ready_i    (opq_ready_i[q]),
      .opq_cmd_valid_o(opq_cmd_valid_o[q]),
      .last_i         (q_last[q]),
      .load_o         (q_load[q]),
      .breq           (breq[q])
    );

    word_counter i_word_counter (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .load_i  (q_load[q]),
      .cmd_vs_i(cmd_vs_i[q]),
      .cmd_eew_i(cmd_eew_i[q]),
      .cmd_vl_i(cmd_vl_i[q]),
      .step_i  (q_issued[q]),
      .words_o (opq_cmd_words_o[q]),
      .last_o  (q_last[q]),
      .breq    (breq[q])
    );
  end

  assign operand_issued_o = q_issued;

  //////////////////////////////////////////////////
  // Bank arbiters
  //////////////////////////////////////////////////

  for (genvar b = 0; b < NrBanks; b++) begin : gen_bank
    bank_arbiter #(
      .NrBanks (NrBanks),
      .NrQueues(NrQueues),
      .BankIdx (b)
    ) i_bank_arbiter (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .breq       (breq),
      .wb_req_i   (wb_req_i),
      .wb_addr_i  (wb_addr_i),
      .wb_wdata_i (wb_wdata_i),
      .wb_gnt_o   (bank_wb_gnt[b]),
      .vrf_req_o  (vrf_req_o[b]),
      .vrf_addr_o (vrf_addr_o[b]),
      .vrf_wen_o  (vrf_wen_o[b]),
      .vrf_wdata_o(vrf_wdata_o[b]),
      .vrf_tgt_o  (vrf_tgt_o[b])
    );
  end

  // Only the bank that the address selects can grant the write-back
  assign wb_gnt_o = |bank_wb_gnt;

endmodule

// ==== sim/operand_requester_sva.sv ====
// Bank arbiter assertions
// Request forwarding and one-hot grants of a single VRF bank

`timescale 1ns/10ps

module operand_requester_sva #(
  parameter int unsigned NrBanks = 4,
  parameter int unsigned BankIdx = 0,
  parameter int unsigned NrIn    = 3
) (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic              [NrIn-1:0] in_valid_i,
  input opreq_pkg::vaddr_t [NrIn-1:0] in_addr_i,
  input logic              [NrIn-1:0] gnt_i,
  input logic                         vrf_req_i
);

  int              fails = 0;
  logic [NrIn-1:0] bank_hit;

  // Requests whose word address falls in this bank
  always_comb begin
    for (int i = 0; i < NrIn; i++) begin
      bank_hit[i] = in_valid_i[i] && ((in_addr_i[i] % NrBanks) == BankIdx);
    end
  end

  // Bank port is requested whenever any input targets this bank
  assert property (@(posedge clk_i) disable iff (!rst_ni) vrf_req_i == (|bank_hit))
    else begin
      $error("bank request does not follow the matching requests");
      fails++;
    end

  // Never more than one winner per cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(gnt_i))
    else begin
      $error("more than one grant in one cycle on a bank");
      fails++;
    end

endmodule

bind bank_arbiter operand_requester_sva #(
  .NrBanks(NrBanks),
  .BankIdx(BankIdx),
  .NrIn   (NrQueues + 1)
) i_sva (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .in_valid_i(in_valid),
  .in_addr_i (in_addr),
  .gnt_i     (gnt_vec),
  .vrf_req_i (vrf_req_o)
);

// ==== sim/operand_checker.sv ====
// Operand requester checker
// Predicts word counts, read addresses, grant order and write-backs from the DUT ports

`timescale 1ns/10ps

module operand_checker #(
  parameter int unsigned NrBanks  = 4,
  parameter int unsigned NrQueues = 2,
  parameter int unsigned RowWidth = 8,
  parameter int unsigned TgtWidth = 1
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic             [NrQueues-1:0]        cmd_valid_i,
  input  logic             [NrQueues-1:0]        cmd_ready_i,
  input  opreq_pkg::vreg_t [NrQueues-1:0]        cmd_vs_i,
  input  opreq_pkg::eew_e  [NrQueues-1:0]        cmd_eew_i,
  input  opreq_pkg::vlen_t [NrQueues-1:0]        cmd_vl_i,
  input  logic             [NrQueues-1:0]        opq_ready_i,
  input  logic             [NrQueues-1:0]        opq_cmd_valid_i,
  input  opreq_pkg::vlen_t [NrQueues-1:0]        opq_cmd_words_i,
  input  logic             [NrQueues-1:0]        operand_issued_i,
  input  logic                                   wb_req_i,
  input  opreq_pkg::vaddr_t                      wb_addr_i,
  input  opreq_pkg::elen_t                       wb_wdata_i,
  input  logic                                   wb_gnt_i,
  input  logic             [NrBanks-1:0]               vrf_req_i,
  input  logic             [NrBanks-1:0][RowWidth-1:0] vrf_addr_i,
  input  logic             [NrBanks-1:0]               vrf_wen_i,
  input  opreq_pkg::elen_t [NrBanks-1:0]               vrf_wdata_i,
  input  logic             [NrBanks-1:0][TgtWidth-1:0] vrf_tgt_i,
  output int                                     errors_o,
  output logic                                   idle_o
);
  import opreq_pkg::*;

  localparam int unsigned BankBits = $clog2(NrBanks);

  int     errors;
  int     remaining [NrQueues];
  vaddr_t next_addr [NrQueues];
  // Last input served by each bank, NrQueues stands for the write-back
  int     last_win  [NrBanks];
  logic   after_reset;

  // Elements per word halve with each step up in width
  function automatic int words_for(input eew_e eew, input vlen_t vl);
    int epw;
    epw = 8 >> int'(eew);
    return (int'(vl) + epw - 1) / epw;
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
    errors++;
  endtask

  task automatic report_failure(input string msg);
    $display("error at %0t: %s", $time, msg);
    errors++;
  endtask

  //////////////////////////////////////////////////
  // Per-cycle comparison
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin : check_cycle
    int     reads;
    int     hit_bank;
    int     contenders;
    int     exp_win;
    int     win;
    int     writes;
    int     wb_bank;
    int     exp_words;
    logic   exp_opq;
    vaddr_t got_addr;
    if (!rst_ni) begin
      for (int q = 0; q < NrQueues; q++) begin
        remaining[q] = 0;
        next_addr[q] = '0;
      end
      for (int b = 0; b < NrBanks; b++) begin
        last_win[b] = NrQueues;
      end
      after_reset = 1'b1;
    end else begin
      if (after_reset) begin
        if (cmd_ready_i != '0 || opq_cmd_valid_i != '0 || vrf_req_i != '0 || wb_gnt_i ||
            operand_issued_i != '0) begin
          report_failure("outputs not idle in the first cycle after reset");
        end
        after_reset = 1'b0;
      end
      // Round-robin order when every queue wants the same bank
      for (int b = 0; b < NrBanks; b++) begin
        contenders = 0;
        for (int q = 0; q < NrQueues; q++) begin
          if (remaining[q] > 0 && opq_ready_i[q] &&
              int'(next_addr[q][BankBits-1:0]) == b) begin
            contenders++;
          end
        end
        if (contenders == NrQueues &&
            !(wb_req_i && int'(wb_addr_i[BankBits-1:0]) == b)) begin
          exp_win = (last_win[b] + 1) % (NrQueues + 1);
          if (exp_win == NrQueues) exp_win = 0;
          win = (vrf_req_i[b] && !vrf_wen_i[b]) ? int'(vrf_tgt_i[b]) : -1;
          if (win != exp_win) begin
            report_mismatch($sformatf("vrf_tgt_o[%0d]", b), 64'(win), 64'(exp_win));
          end
        end
        if (vrf_req_i[b]) begin
          last_win[b] = vrf_wen_i[b] ? NrQueues : int'(vrf_tgt_i[b]);
        end
      end
      for (int q = 0; q < NrQueues; q++) begin
        reads    = 0;
        hit_bank = 0;
        for (int b = 0; b < NrBanks; b++) begin
          if (vrf_req_i[b] && !vrf_wen_i[b] && int'(vrf_tgt_i[b]) == q) begin
            reads++;
            hit_bank = b;
          end
        end
        if (reads > 1) report_failure($sformatf("queue %0d read from two banks at once", q));
        if (operand_issued_i[q] != (reads == 1)) begin
          report_mismatch($sformatf("operand_issued_o[%0d]", q), 64'(operand_issued_i[q]),
                          64'(reads == 1));
        end
        if (reads == 1) begin
          got_addr = {vrf_addr_i[hit_bank], hit_bank[BankBits-1:0]};
          if (!opq_ready_i[q]) begin
            report_failure($sformatf("read for queue %0d while its operand queue was full", q));
          end
          if (remaining[q] == 0) begin
            report_failure($sformatf("read for queue %0d with no words outstanding", q));
          end else begin
            if (got_addr != next_addr[q]) begin
              report_mismatch($sformatf("read address of queue %0d", q), 64'(got_addr),
                              64'(next_addr[q]));
            end
            next_addr[q] = next_addr[q] + vaddr_t'(1);
            remaining[q]--;
          end
        end
        // A new command may be taken in the cycle of the last word
        exp_opq = 1'b0;
        if (cmd_valid_i[q] && cmd_ready_i[q]) begin
          if (remaining[q] != 0) begin
            report_failure($sformatf("queue %0d took a command with words outstanding", q));
          end
          exp_words = words_for(cmd_eew_i[q], cmd_vl_i[q]);
          if (exp_words > 0) begin
            exp_opq = 1'b1;
            if (opq_cmd_words_i[q] != vlen_t'(exp_words)) begin
              report_mismatch($sformatf("opq_cmd_words_o[%0d]", q), 64'(opq_cmd_words_i[q]),
                              64'(exp_words));
            end
            next_addr[q] = vaddr_t'(int'(cmd_vs_i[q]) * int'(RegWords));
            remaining[q] = exp_words;
          end
        end
        if (opq_cmd_valid_i[q] != exp_opq) begin
          report_mismatch($sformatf("opq_cmd_valid_o[%0d]", q), 64'(opq_cmd_valid_i[q]),
                          64'(exp_opq));
        end
      end
      // Write-back lands once in the bank that its address selects
      writes = 0;
      for (int b = 0; b < NrBanks; b++) begin
        if (vrf_req_i[b] && vrf_wen_i[b]) writes++;
      end
      if (wb_gnt_i) begin
        wb_bank = int'(wb_addr_i[BankBits-1:0]);
        if (!wb_req_i) begin
          report_failure("write-back granted with no write-back request");
        end else if (writes != 1 || !(vrf_req_i[wb_bank] && vrf_wen_i[wb_bank])) begin
          report_failure("write-back granted without a single VRF write in its bank");
        end else begin
          if (vrf_addr_i[wb_bank] != wb_addr_i[VAddrWidth-1:BankBits]) begin
            report_mismatch($sformatf("vrf_addr_o[%0d]", wb_bank), 64'(vrf_addr_i[wb_bank]),
                            64'(wb_addr_i[VAddrWidth-1:BankBits]));
          end
          if (vrf_wdata_i[wb_bank] != wb_wdata_i) begin
            report_mismatch($sformatf("vrf_wdata_o[%0d]", wb_bank), vrf_wdata_i[wb_bank],
                            wb_wdata_i);
          end
        end
      end else if (writes != 0) begin
        report_failure("VRF write without a write-back grant");
      end
    end
  end

  always @* begin
    idle_o = 1'b1;
    for (int q = 0; q < NrQueues; q++) begin
      if (remaining[q] != 0) idle_o = 1'b0;
    end
  end

  assign errors_o = errors;

  initial errors = 0;

endmodule

// ==== sim/tb_operand_requester.sv ====
// Operand requester testbench
// Applies a table of read commands and write-backs, with fixed or random queue back-pressure

`timescale 1ns/10ps

module tb_operand_requester;
  import opreq_pkg::*;

  localparam int unsigned NrBanks    = 4;
  localparam int unsigned NrQueues   = 2;
  localparam int unsigned RowWidth   = VAddrWidth - $clog2(NrBanks);
  localparam int unsigned TgtWidth   = 1;
  localparam int          NumEntries = 11;

  typedef struct {
    int     queue;
    vreg_t  vs;
    eew_e   eew;
    vlen_t  vl;
    logic   rnd_ready;
    logic   paired;
    logic   wb_en;
    vaddr_t wb_addr;
    elen_t  wb_data;
  } stim_t;

  logic                                 clk_i;
  logic                                 rst_ni;
  logic  [NrQueues-1:0]                 cmd_valid;
  logic  [NrQueues-1:0]                 cmd_ready;
  vreg_t [NrQueues-1:0]                 cmd_vs;
  eew_e  [NrQueues-1:0]                 cmd_eew;
  vlen_t [NrQueues-1:0]                 cmd_vl;
  logic  [NrQueues-1:0]                 opq_ready;
  logic  [NrQueues-1:0]                 opq_cmd_valid;
  vlen_t [NrQueues-1:0]                 opq_cmd_words;
  logic  [NrQueues-1:0]                 operand_issued;
  logic                                 wb_req;
  vaddr_t                               wb_addr;
  elen_t                                wb_wdata;
  logic                                 wb_gnt;
  logic  [NrBanks-1:0]                  vrf_req;
  logic  [NrBanks-1:0][RowWidth-1:0]    vrf_addr;
  logic  [NrBanks-1:0]                  vrf_wen;
  elen_t [NrBanks-1:0]                  vrf_wdata;
  logic  [NrBanks-1:0][TgtWidth-1:0]    vrf_tgt;

  stim_t               stim [NumEntries];
  int                  num_filled;
  logic [NrQueues-1:0] rnd_mode;
  logic [31:0]         lfsr;
  int                  cycles;
  int                  limit = 1000000;
  int                  chk_errors;
  logic                chk_idle;
  int                  sva_fails [NrBanks];

  operand_requester_top #(
    .NrBanks (NrBanks),
    .NrQueues(NrQueues)
  ) dut (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .cmd_valid_i(cmd_valid), .cmd_ready_o(cmd_ready), .cmd_vs_i(cmd_vs),
    .cmd_eew_i(cmd_eew), .cmd_vl_i(cmd_vl),
    .opq_ready_i(opq_ready), .opq_cmd_valid_o(opq_cmd_valid),
    .opq_cmd_words_o(opq_cmd_words), .operand_issued_o(operand_issued),
    .wb_req_i(wb_req), .wb_addr_i(wb_addr), .wb_wdata_i(wb_wdata), .wb_gnt_o(wb_gnt),
    .vrf_req_o(vrf_req), .vrf_addr_o(vrf_addr), .vrf_wen_o(vrf_wen),
    .vrf_wdata_o(vrf_wdata), .vrf_tgt_o(vrf_tgt)
  );

  operand_checker #(
    .NrBanks(NrBanks), .NrQueues(NrQueues), .RowWidth(RowWidth), .TgtWidth(TgtWidth)
  ) i_checker (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .cmd_valid_i(cmd_valid), .cmd_ready_i(cmd_ready), .cmd_vs_i(cmd_vs),
    .cmd_eew_i(cmd_eew), .cmd_vl_i(cmd_vl),
    .opq_ready_i(opq_ready), .opq_cmd_valid_i(opq_cmd_valid),
    .opq_cmd_words_i(opq_cmd_words), .operand_issued_i(operand_issued),
    .wb_req_i(wb_req), .wb_addr_i(wb_addr), .wb_wdata_i(wb_wdata), .wb_gnt_i(wb_gnt),
    .vrf_req_i(vrf_req), .vrf_addr_i(vrf_addr), .vrf_wen_i(vrf_wen),
    .vrf_wdata_i(vrf_wdata), .vrf_tgt_i(vrf_tgt),
    .errors_o(chk_errors), .idle_o(chk_idle)
  );

  // Assertion failures of every bank arbiter
  for (genvar b = 0; b < NrBanks; b++) begin : gen_sva_fails
    assign sva_fails[b] = dut.gen_bank[b].i_bank_arbiter.i_sva.fails;
  end

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Galois LFSR, taps of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  function automatic int word_count(input eew_e eew, input vlen_t vl);
    int epw;
    epw = 8 >> int'(eew);
    return (int'(vl) + epw - 1) / epw;
  endfunction

  task automatic add_entry(input int q, input vreg_t vs, input eew_e eew, input vlen_t vl,
                           input logic rnd, input logic paired, input logic wb_en,
                           input vaddr_t addr, input elen_t data);
    stim[num_filled] = '{q, vs, eew, vl, rnd, paired, wb_en, addr, data};
    num_filled++;
  endtask

  // Queue back-pressure, one LFSR bit per random queue and cycle
  always @(negedge clk_i) begin
    for (int q = 0; q < NrQueues; q++) begin
      if (rnd_mode[q]) begin
        opq_ready[q] = lfsr[0];
        lfsr         = lfsr_step(lfsr);
      end else begin
        opq_ready[q] = 1'b1;
      end
    end
  end

  // Drives count commands at once and holds each until it is taken
  task automatic issue_cmds(input int first, input int count);
    logic [NrQueues-1:0] pending;
    int                  q;
    pending = '0;
    for (int k = 0; k < count; k++) begin
      q            = stim[first + k].queue;
      cmd_valid[q] = 1'b1;
      cmd_vs[q]    = stim[first + k].vs;
      cmd_eew[q]   = stim[first + k].eew;
      cmd_vl[q]    = stim[first + k].vl;
      rnd_mode[q]  = stim[first + k].rnd_ready;
      pending[q]   = 1'b1;
    end
    while (pending != '0) begin
      @(posedge clk_i);
      for (int k = 0; k < NrQueues; k++) begin
        if (pending[k] && cmd_ready[k]) pending[k] = 1'b0;
      end
      @(negedge clk_i);
      for (int k = 0; k < NrQueues; k++) begin
        if (!pending[k]) cmd_valid[k] = 1'b0;
      end
    end
  endtask

  task automatic write_back(input vaddr_t addr, input elen_t data);
    wb_req   = 1'b1;
    wb_addr  = addr;
    wb_wdata = data;
    @(posedge clk_i);
    while (!wb_gnt) @(posedge clk_i);
    @(negedge clk_i);
    wb_req = 1'b0;
  endtask

  initial begin : watchdog
    cycles = 0;
    @(posedge clk_i);
    while (cycles < limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout: the DUT did not finish within %0d cycles", limit);
    $display("Test failed");
    $finish;
  end

  initial begin : stimulus
    int i;
    int sum;
    int n;
    int sva_total;
    rst_ni    = 1'b0;
    cmd_valid = '0;
    cmd_vs    = '0;
    cmd_eew   = '{default: EW8};
    cmd_vl    = '0;
    opq_ready = '1;
    rnd_mode  = '0;
    wb_req    = 1'b0;
    wb_addr   = '0;
    wb_wdata  = '0;
    lfsr      = 32'hfce5;
    num_filled = 0;
    //        q  vs      eew   vl       rnd   pair  wb    wb_addr   wb_data
    add_entry(0, 5'd1,  EW8,  9'd37,  1'b0, 1'b0, 1'b0, 10'h000, 64'h0);
    add_entry(1, 5'd2,  EW16, 9'd13,  1'b0, 1'b0, 1'b0, 10'h000, 64'h0);
    add_entry(0, 5'd3,  EW32, 9'd16,  1'b1, 1'b0, 1'b0, 10'h000, 64'h0);
    add_entry(1, 5'd4,  EW64, 9'd6,   1'b1, 1'b0, 1'b0, 10'h000, 64'h0);
    add_entry(0, 5'd5,  EW8,  9'd0,   1'b0, 1'b0, 1'b0, 10'h000, 64'h0);
    add_entry(0, 5'd6,  EW64, 9'd3,   1'b0, 1'b0, 1'b0, 10'h000, 64'h0);
    // Both queues hit bank 0 in the same cycle
    add_entry(0, 5'd0,  EW64, 9'd8,   1'b0, 1'b1, 1'b0, 10'h000, 64'h0);
    add_entry(1, 5'd1,  EW64, 9'd8,   1'b0, 1'b0, 1'b0, 10'h000, 64'h0);
    add_entry(1, 5'd7,  EW16, 9'd20,  1'b0, 1'b0, 1'b1, 10'h13b, 64'hdead_beef_0123_4567);
    add_entry(0, 5'd10, EW8,  9'd255, 1'b0, 1'b0, 1'b1, 10'h052, 64'h89ab_cdef_fedc_ba98);
    add_entry(1, 5'd31, EW32, 9'd15,  1'b0, 1'b0, 1'b0, 10'h000, 64'h0);
    sum = 0;
    for (int k = 0; k < NumEntries; k++) begin
      sum += 4 * word_count(stim[k].eew, stim[k].vl);
    end
    limit = sum + 100;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    i = 0;
    while (i < NumEntries) begin
      n = stim[i].paired ? 2 : 1;
      issue_cmds(i, n);
      if (stim[i].wb_en) write_back(stim[i].wb_addr, stim[i].wb_data);
      while (!chk_idle) @(negedge clk_i);
      i += n;
    end
    repeat (2) @(negedge clk_i);
    sva_total = 0;
    for (int b = 0; b < NrBanks; b++) begin
      sva_total += sva_fails[b];
    end
    $display("errors: checker %0d, assertions %0d", chk_errors, sva_total);
    if (chk_errors == 0 && sva_total == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== all.f ====
src/opreq_pkg.sv
src/bank_req_if.sv
src/requester_fsm.sv
src/word_counter.sv
src/bank_arbiter.sv
src/operand_requester_top.sv
sim/operand_requester_sva.sv
sim/operand_checker.sv
sim/tb_operand_requester.sv

// ==== Makefile ====
# Verilator build and run of the operand requester testbench

VERILATOR ?= verilator
TOP       ?= tb_operand_requester
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Test passed

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
